// File: common/mem_consts.svh
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// bus widths
`define MEM_ADDR_W 32
`define MEM_WORD_W 32
`define MEM_BYTE_W 8

// wide enough to hold a length of 4
`define MEM_LEN_W 3

// instruction fetch is always a full word
`define FETCH_LEN 4

// byte addressed ram
`define ADDR_STEP 1

`endif

// File: common/memTypesPkg.sv
package memTypesPkg;

`include "mem_consts.svh"

    // byte address on both the core and the ram side
    typedef logic [`MEM_ADDR_W-1:0] addrT;

    // instruction or data word
    typedef logic [`MEM_WORD_W-1:0] wordT;

    // one ram transfer
    typedef logic [`MEM_BYTE_W-1:0] byteT;

    // transfer length in bytes, 1, 2 or 4
    typedef logic [`MEM_LEN_W-1:0] lenT;

endpackage

// File: common/ctrlPkg.sv
package ctrlPkg;

`include "mem_consts.svh"

    // sequencer states
    typedef enum logic [1:0] {
        stIdle,
        stIssue,
        stDrain,
        stFinish
    } ctrlStateT;

    // owner of the transfer in flight
    typedef enum logic {
        clFetch,
        clData
    } clientT;

    // byte position within a transfer
    typedef logic [`MEM_LEN_W-1:0] byteCntT;

endpackage

// File: common/memReqIf.sv
`timescale 1ns/1ps

interface memReqIf;
    import memTypesPkg::*;

    // one-cycle pulse, only while the sequencer is idle
    logic start;

    // held steady from start until done
    logic write;
    addrT addr;
    lenT  len;
    wordT wdata;

    // completion, rdata valid with done
    logic done;
    wordT rdata;

    modport arbiter (
        output start,
        output write,
        output addr,
        output len,
        output wdata,
        input  done,
        input  rdata
    );

    modport sequencer (
        input  start,
        input  write,
        input  addr,
        input  len,
        input  wdata,
        output done,
        output rdata
    );

endinterface

// File: memctrl/portArbiter.sv
`timescale 1ns/1ps
`include "mem_consts.svh"

module portArbiter (
    input  logic              clk,
    input  logic              rst,
    input  logic              i_freeze,

    input  logic              i_fetchEn,
    input  memTypesPkg::addrT i_fetchAddr,
    output logic              o_fetchDone,
    output memTypesPkg::wordT o_fetchInst,

    input  logic              i_dataEn,
    input  logic              i_dataWrite,
    input  memTypesPkg::lenT  i_dataLen,
    input  memTypesPkg::addrT i_dataAddr,
    input  memTypesPkg::wordT i_dataWdata,
    output logic              o_dataDone,
    output memTypesPkg::wordT o_dataRdata,

    memReqIf.arbiter          req
);
    import memTypesPkg::*;
    import ctrlPkg::*;

    logic   busy;
    logic   startQ;
    clientT owner;

    logic   reqWrite;
    lenT    reqLen;
    addrT   reqAddr;
    wordT   reqWdata;

    logic   accept;
    clientT winner;

    // data port has priority
    assign winner = i_dataEn ? clData : clFetch;
    assign accept = !busy && (i_dataEn || i_fetchEn);

    always_ff @(posedge clk) begin
        if (rst) begin
            busy   <= 1'b0;
            startQ <= 1'b0;
            owner  <= clFetch;
        end else if (!i_freeze) begin
            startQ <= accept;
            if (accept) begin
                busy  <= 1'b1;
                owner <= winner;
            end else if (req.done) begin
                busy <= 1'b0;
            end
        end
    end

    // latched request, stays put until done
    always_ff @(posedge clk) begin
        if (!i_freeze && accept) begin
            if (winner == clData) begin
                reqWrite <= i_dataWrite;
                reqLen   <= i_dataLen;
                reqAddr  <= i_dataAddr;
                reqWdata <= i_dataWdata;
            end else begin
                reqWrite <= 1'b0;
                reqLen   <= lenT'(`FETCH_LEN);
                reqAddr  <= i_fetchAddr;
                reqWdata <= '0;
            end
        end
    end

    assign req.start = startQ;
    assign req.write = reqWrite;
    assign req.len   = reqLen;
    assign req.addr  = reqAddr;
    assign req.wdata = reqWdata;

    // completion goes back to whoever owns the transfer
    assign o_fetchDone = req.done && (owner == clFetch);
    assign o_dataDone  = req.done && (owner == clData);
    assign o_fetchInst = (owner == clFetch) ? req.rdata : '0;
    assign o_dataRdata = (owner == clData) ? req.rdata : '0;

endmodule

// File: memctrl/byteSequencer.sv
`timescale 1ns/1ps
`include "mem_consts.svh"

module byteSequencer (
    input  logic              clk,
    input  logic              rst,
    input  logic              i_freeze,

    memReqIf.sequencer        req,

    output logic              o_memWrite,
    output memTypesPkg::addrT o_memAddr,
    output memTypesPkg::byteT o_memWdata,
    input  memTypesPkg::byteT i_memRdata
);
    import memTypesPkg::*;
    import ctrlPkg::*;

    ctrlStateT state;

    // next byte to issue, next byte to come back
    byteCntT   issCnt;
    byteCntT   retCnt;

    // a read byte is on i_memRdata this cycle
    logic      rdValid;

    wordT      rdWord;

    logic      lastIssue;
    byteCntT   addrIdx;

    assign lastIssue = (byteCntT'(issCnt + 1'b1) == req.len);

    // while frozen, keep asking for the byte in flight so it is not lost
    assign addrIdx = (i_freeze && rdValid) ? retCnt : issCnt;

    assign o_memAddr  = req.addr + addrT'(addrIdx) * addrT'(`ADDR_STEP);
    assign o_memWdata = byteT'(req.wdata >> (issCnt * `MEM_BYTE_W));
    assign o_memWrite = (state == stIssue) && req.write && !i_freeze;

    assign req.done  = (state == stFinish) && !i_freeze;
    assign req.rdata = rdWord;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= stIdle;
            issCnt  <= '0;
            retCnt  <= '0;
            rdValid <= 1'b0;
        end else if (!i_freeze) begin
            rdValid <= (state == stIssue) && !req.write;

            if (rdValid) begin
                retCnt <= retCnt + 1'b1;
            end

            case (state)
                stIdle: begin
                    if (req.start) begin
                        state  <= stIssue;
                        issCnt <= '0;
                        retCnt <= '0;
                    end
                end
                stIssue: begin
                    issCnt <= issCnt + 1'b1;
                    if (lastIssue) begin
                        // a store is complete once the last byte is out
                        state <= req.write ? stFinish : stDrain;
                    end
                end
                stDrain: begin
                    // last read byte lands this cycle
                    state <= stFinish;
                end
                stFinish: begin
                    state <= stIdle;
                end
                default: begin
                    state <= stIdle;
                end
            endcase
        end
    end

    // read assembly, little endian, zero above the length
    always_ff @(posedge clk) begin
        if (!i_freeze) begin
            if (state == stIdle && req.start) begin
                rdWord <= '0;
            end else if (rdValid) begin
                rdWord[retCnt*`MEM_BYTE_W +: `MEM_BYTE_W] <= i_memRdata;
            end
        end
    end

endmodule

// File: rtl/memCtrlTop.sv
`timescale 1ns/1ps

module memCtrlTop (
    input  logic              clk,
    input  logic              rst,
    input  logic              i_rdy,
    input  logic              i_ioFull,

    // instruction fetch port
    input  logic              i_fetchEn,
    input  memTypesPkg::addrT i_fetchAddr,
    output logic              o_fetchDone,
    output memTypesPkg::wordT o_fetchInst,

    // data port
    input  logic              i_dataEn,
    input  logic              i_dataWrite,
    input  memTypesPkg::lenT  i_dataLen,
    input  memTypesPkg::addrT i_dataAddr,
    input  memTypesPkg::wordT i_dataWdata,
    output logic              o_dataDone,
    output memTypesPkg::wordT o_dataRdata,

    // byte ram
    output logic              o_memWrite,
    output memTypesPkg::addrT o_memAddr,
    output memTypesPkg::byteT o_memWdata,
    input  memTypesPkg::byteT i_memRdata
);

    logic freeze;

    memReqIf reqBus ();

    // core stalled or io buffer full, nothing moves
    assign freeze = !i_rdy || i_ioFull;

    portArbiter portArbiter_inst (
        .clk         (clk),
        .rst         (rst),
        .i_freeze    (freeze),
        .i_fetchEn   (i_fetchEn),
        .i_fetchAddr (i_fetchAddr),
        .o_fetchDone (o_fetchDone),
        .o_fetchInst (o_fetchInst),
        .i_dataEn    (i_dataEn),
        .i_dataWrite (i_dataWrite),
        .i_dataLen   (i_dataLen),
        .i_dataAddr  (i_dataAddr),
        .i_dataWdata (i_dataWdata),
        .o_dataDone  (o_dataDone),
        .o_dataRdata (o_dataRdata),
        .req         (reqBus.arbiter)
    );

    byteSequencer byteSequencer_inst (
        .clk        (clk),
        .rst        (rst),
        .i_freeze   (freeze),
        .req        (reqBus.sequencer),
        .o_memWrite (o_memWrite),
        .o_memAddr  (o_memAddr),
        .o_memWdata (o_memWdata),
        .i_memRdata (i_memRdata)
    );

endmodule

// File: bench/byteRamModel.sv
`timescale 1ns/1ps

module byteRamModel (
    input  logic              clk,
    input  logic              i_write,
    input  memTypesPkg::addrT i_addr,
    input  memTypesPkg::byteT i_wdata,
    output memTypesPkg::byteT o_rdata
);
    import memTypesPkg::*;

    byteT mem [256];

    // every cell differs, odd multiplier covers all index bits
    initial begin
        int i;
        for (i = 0; i < 256; i++) begin
            mem[i] = byteT'(i * 37) ^ 8'h5A;
        end
    end

    // read data shows up one cycle after the address
    always @(posedge clk) begin
        if (i_write) begin
            mem[i_addr[7:0]] <= i_wdata;
        end
        o_rdata <= mem[i_addr[7:0]];
    end

endmodule

// File: bench/memCtrl_checker.sv
`timescale 1ns/1ps

module memCtrl_checker (
    input logic clk,
    input logic rst,
    input logic i_rdy,
    input logic i_ioFull,
    input logic o_memWrite,
    input logic o_fetchDone,
    input logic o_dataDone
);
    int   assertFails = 0;
    logic frozen;

    assign frozen = !i_rdy || i_ioFull;

    quietWhileFrozen: assert property (@(posedge clk) disable iff (rst)
        frozen |-> (!o_memWrite && !o_fetchDone && !o_dataDone))
        else begin
            assertFails++;
            $error("ram write or done pulse while frozen");
        end

    fetchDonePulse: assert property (@(posedge clk) disable iff (rst)
        o_fetchDone |=> !o_fetchDone)
        else begin
            assertFails++;
            $error("fetch done held longer than one cycle");
        end

    dataDonePulse: assert property (@(posedge clk) disable iff (rst)
        o_dataDone |=> !o_dataDone)
        else begin
            assertFails++;
            $error("data done held longer than one cycle");
        end

endmodule

bind memCtrlTop memCtrl_checker checkerInst (
    .clk         (clk),
    .rst         (rst),
    .i_rdy       (i_rdy),
    .i_ioFull    (i_ioFull),
    .o_memWrite  (o_memWrite),
    .o_fetchDone (o_fetchDone),
    .o_dataDone  (o_dataDone)
);

// File: bench/memCtrlTb.sv
`timescale 1ns/1ps
`include "mem_consts.svh"

module memCtrlTb;
    import memTypesPkg::*;

    localparam logic [1:0] KFETCH = 2'd0;
    localparam logic [1:0] KDATA  = 2'd1;
    localparam logic [1:0] KBOTH  = 2'd2;
    localparam int NROWS   = 17;
    localparam int TIMEOUT = NROWS * 40;

    typedef struct packed {
        logic [1:0] kind;
        logic       write;
        lenT        len;
        addrT       addr;
        addrT       fAddr;
        wordT       wdata;
        logic       frz;
    } rowT;

    logic clk = 1'b0;
    logic rst;
    logic i_rdy, i_ioFull;
    logic i_fetchEn, o_fetchDone;
    addrT i_fetchAddr;
    wordT o_fetchInst;
    logic i_dataEn, i_dataWrite, o_dataDone;
    lenT  i_dataLen;
    addrT i_dataAddr;
    wordT i_dataWdata, o_dataRdata;
    logic o_memWrite;
    addrT o_memAddr;
    byteT o_memWdata, i_memRdata;

    rowT    rows [NROWS];
    byteT   shadow [256];
    int     errors = 0;
    int     cycles = 0;
    integer seed = 10;

    always #2 clk = !clk;

    memCtrlTop memCtrlTop_inst (.*);

    byteRamModel ramModel_inst (
        .clk     (clk),
        .i_write (o_memWrite),
        .i_addr  (o_memAddr),
        .i_wdata (o_memWdata),
        .o_rdata (i_memRdata)
    );

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("timeout: transfers still open after %0d cycles", cycles);
            $display("=== FAIL ===");
            $finish;
        end
    end

    task automatic checkEq(input wordT got, input wordT exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s: got %h expected %h", $time, what, got, exp);
        end
    endtask

    function automatic wordT readShadow(input addrT a, input int n);
        wordT w;
        int   k;
        w = '0;
        for (k = 0; k < n; k++) begin
            w[k*8 +: 8] = shadow[8'(a + addrT'(k))];
        end
        return w;
    endfunction

    task automatic writeShadow(input addrT a, input int n, input wordT d);
        int k;
        for (k = 0; k < n; k++) begin
            shadow[8'(a + addrT'(k))] = d[k*8 +: 8];
        end
    endtask

    task automatic driveFreeze(input logic frz);
        if (frz) begin
            i_rdy    = (($random(seed) & 3) != 0);
            i_ioFull = (($random(seed) & 7) == 0);
        end else begin
            i_rdy    = 1'b1;
            i_ioFull = 1'b0;
        end
    endtask

    // kind, write, len, data addr, fetch addr, wdata, freeze
    task automatic loadTable();
        rows[0]  = '{KFETCH, 1'b0, 3'd4, 32'h00, 32'h10, 32'h0, 1'b0};
        rows[1]  = '{KDATA,  1'b0, 3'd1, 32'h21, 32'h00, 32'h0, 1'b0};
        rows[2]  = '{KDATA,  1'b0, 3'd2, 32'h32, 32'h00, 32'h0, 1'b0};
        rows[3]  = '{KDATA,  1'b0, 3'd4, 32'h40, 32'h00, 32'h0, 1'b0};
        rows[4]  = '{KDATA,  1'b1, 3'd1, 32'h51, 32'h00, 32'h000000C3, 1'b0};
        rows[5]  = '{KDATA,  1'b0, 3'd4, 32'h50, 32'h00, 32'h0, 1'b0};
        rows[6]  = '{KDATA,  1'b1, 3'd2, 32'h61, 32'h00, 32'h0000BEEF, 1'b0};
        rows[7]  = '{KDATA,  1'b0, 3'd4, 32'h60, 32'h00, 32'h0, 1'b0};
        rows[8]  = '{KDATA,  1'b1, 3'd4, 32'h70, 32'h00, 32'h12345678, 1'b0};
        rows[9]  = '{KDATA,  1'b0, 3'd2, 32'h72, 32'h00, 32'h0, 1'b0};
        rows[10] = '{KBOTH,  1'b0, 3'd4, 32'h70, 32'h80, 32'h0, 1'b0};
        rows[11] = '{KBOTH,  1'b1, 3'd2, 32'h91, 32'h90, 32'h0000A1B2, 1'b0};
        rows[12] = '{KFETCH, 1'b0, 3'd4, 32'h00, 32'h10, 32'h0, 1'b1};
        rows[13] = '{KDATA,  1'b0, 3'd2, 32'h51, 32'h00, 32'h0, 1'b1};
        rows[14] = '{KDATA,  1'b1, 3'd4, 32'hA0, 32'h00, 32'hCAFEF00D, 1'b1};
        rows[15] = '{KDATA,  1'b0, 3'd4, 32'h9F, 32'h00, 32'h0, 1'b1};
        rows[16] = '{KBOTH,  1'b0, 3'd1, 32'hA3, 32'hA0, 32'h0, 1'b1};
    endtask

    task automatic idleCheck(input int n);
        repeat (n) begin
            @(negedge clk);
            checkEq(wordT'({o_fetchDone, o_dataDone, o_memWrite}), '0, "idle outputs");
        end
    endtask

    initial begin
        rowT  row;
        logic useData, useFetch, gotData, gotFetch;
        wordT expData, expFetch;
        int   r;
        int   i;

        rst         = 1'b1;
        i_rdy       = 1'b1;
        i_ioFull    = 1'b0;
        i_fetchEn   = 1'b0;
        i_fetchAddr = '0;
        i_dataEn    = 1'b0;
        i_dataWrite = 1'b0;
        i_dataLen   = '0;
        i_dataAddr  = '0;
        i_dataWdata = '0;
        loadTable();
        for (i = 0; i < 256; i++) begin
            shadow[i] = byteT'(i * 37) ^ 8'h5A;
        end

        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        idleCheck(4);

        for (r = 0; r < NROWS; r++) begin
            row      = rows[r];
            useData  = (row.kind != KFETCH);
            useFetch = (row.kind != KDATA);
            gotData  = 1'b0;
            gotFetch = 1'b0;

            // data wins arbitration, so a store lands before the fetch reads
            expData = '0;
            if (useData && !row.write) begin
                expData = readShadow(row.addr, int'(row.len));
            end
            if (useData && row.write) begin
                writeShadow(row.addr, int'(row.len), row.wdata);
            end
            expFetch = readShadow(row.fAddr, `FETCH_LEN);

            i_dataEn    = useData;
            i_dataWrite = row.write;
            i_dataLen   = row.len;
            i_dataAddr  = row.addr;
            i_dataWdata = row.wdata;
            i_fetchEn   = useFetch;
            i_fetchAddr = row.fAddr;
            driveFreeze(row.frz);

            while ((useData && !gotData) || (useFetch && !gotFetch)) begin
                @(negedge clk);
                if (o_dataDone) begin
                    checkEq(wordT'(useData && !gotData), 1, "data done expected");
                    if (!row.write) begin
                        checkEq(o_dataRdata, expData, "data load");
                    end
                    gotData  = 1'b1;
                    i_dataEn = 1'b0;
                end
                if (o_fetchDone) begin
                    checkEq(wordT'(useFetch && !gotFetch), 1, "fetch done expected");
                    checkEq(wordT'(gotData || !useData), 1, "data done before fetch");
                    checkEq(o_fetchInst, expFetch, "fetch word");
                    gotFetch  = 1'b1;
                    i_fetchEn = 1'b0;
                end
                driveFreeze(row.frz);
            end

            driveFreeze(1'b0);
            idleCheck(3);
        end

        errors += memCtrlTop_inst.checkerInst.assertFails;
        $display("run complete: %0d errors, %0d from assertions", errors,
                 memCtrlTop_inst.checkerInst.assertFails);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: src.f
+incdir+common
common/memTypesPkg.sv
common/ctrlPkg.sv
common/memReqIf.sv
memctrl/portArbiter.sv
memctrl/byteSequencer.sv
rtl/memCtrlTop.sv
bench/byteRamModel.sv
bench/memCtrl_checker.sv
bench/memCtrlTb.sv

// File: Makefile
TOOL      = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = memCtrlTb
FILELIST  = src.f
BUILD_DIR = obj_dir
LOG       = sim.log
RUN_FLAGS = +verilator+error+limit+100
PASS_MSG  = === PASS ===

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
